// ==== lpc_levinson.f ====
source/ld_pkg.sv
source/ld_control.sv
source/ld_recip_div.sv
source/ld_datapath.sv
source/ld_coef_out.sv
source/levinson_durbin.sv
testbench/tb_levinson_durbin.sv

// ==== testbench/levinson_golden.txt ====
// per vector: one line of 11 autocorrelation words R0..R10 (48-bit sign-magnitude, 16 fraction bits)
// then one line of 11 expected lpc words a0..a10 (low 32 bits)
// resonant second-order frame
000000010000 000000008000 000000008000 000000005555 00000000471b 000000003424 000000002914 000000001f12 00000000180c 00000000125f 000000000e22
00010000 00005556 00005555 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
// near-white frame, fast decaying correlation
000000010000 000000001000 000000000100 000000000010 000000000001 000000000000 000000000000 000000000000 000000000000 000000000000 000000000000
00010000 00001000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
// R1 above R0, first reflection clamps to zero
000000010000 000000018000 000000004000 000000006000 000000001000 000000001800 000000000400 000000000600 000000000100 000000000180 000000000040
00010000 00000000 00004000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

// ==== testbench/tb_levinson_durbin.sv ====
// self-checking testbench for the levinson-durbin solver against golden vectors
`timescale 1ns/1ps
`default_nettype none

module tb_levinson_durbin
	import ld_pkg::*;
;

	localparam int NUM_VEC     = 3;
	localparam int VEC_WORDS   = 2 * (LD_ORDER + 1);
	// five runs of roughly 640 cycles each
	localparam int CYCLE_LIMIT = NUM_VEC * 1500;

	logic     clk;
	logic     rst;
	logic     start;
	ld_rvec_t r;
	ld_out_t  lpc;
	ld_idx_t  lpc_addr;
	logic     lpc_valid;
	logic     done;

	logic [LD_WIDTH-1:0] golden [0:NUM_VEC*VEC_WORDS-1];

	int   err_cnt;
	int   fail_cnt;
	int   cycle_cnt;
	int   exp_vec;
	int   word_cnt;
	int   done_total;
	logic armed;
	logic prev_last;

	levinson_durbin u_levinson_durbin (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.r         (r),
		.lpc       (lpc),
		.lpc_addr  (lpc_addr),
		.lpc_valid (lpc_valid),
		.done      (done)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [LD_WIDTH-1:0] exp_val,
		input logic [LD_WIDTH-1:0] act_val);
		if (exp_val !== act_val)
		begin
			err_cnt++;
			$display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp_val, act_val);
		end
	endtask

	task automatic report_failure(input string what);
		fail_cnt++;
		$display("t=%0t %s", $time, what);
	endtask

	task automatic load_vector(input int v);
		for (int k = 0; k <= LD_ORDER; k++)
			r[k] = golden[v*VEC_WORDS + k];
	endtask

	task automatic wait_runs(input int count);
		int target;
		target = done_total + count;
		while (done_total < target)
			@(posedge clk);
	endtask

	// ----------------------------------------
	// output monitor, sampled mid-cycle
	// ----------------------------------------
	always @(negedge clk)
	begin
		if (rst)
		begin
			if (lpc_valid)
			begin
				if (!armed)
					report_failure("lpc_valid high with no run started");
				else if (word_cnt > LD_ORDER)
					report_failure("more than eleven coefficient words in one stream");
				else
				begin
					check_value("lpc_addr", word_cnt, lpc_addr);
					check_value("lpc", golden[exp_vec*VEC_WORDS + LD_ORDER + 1 + word_cnt], lpc);
					// a0 is one, only bit 16 set
					if (word_cnt == 0)
						check_value("lpc", 32'h0001_0000, lpc);
				end
				word_cnt++;
			end
			else if (word_cnt > 0 && word_cnt <= LD_ORDER)
				report_failure("coefficient stream has a gap");
			if (done)
			begin
				if (!prev_last)
					report_failure("done not on the cycle after the address 10 word");
				if (word_cnt != LD_ORDER + 1)
					report_failure("done after an incomplete stream");
				done_total++;
				word_cnt = 0;
			end
			prev_last = lpc_valid && (lpc_addr == ld_idx_t'(LD_ORDER));
		end
	end

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT)
		begin
			$display("timeout: solver did not finish within %0d cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial
	begin
		int gap;
		rst        = 1'b0;
		start      = 1'b0;
		r          = '0;
		err_cnt    = 0;
		fail_cnt   = 0;
		cycle_cnt  = 0;
		exp_vec    = 0;
		word_cnt   = 0;
		done_total = 0;
		armed      = 1'b0;
		prev_last  = 1'b0;
		gap = $urandom(32'h572e);
		$readmemh("testbench/levinson_golden.txt", golden);

		repeat (3) @(posedge clk);
		#1 rst = 1'b1;

		// idle outputs stay quiet
		repeat (8) @(posedge clk);

		for (int v = 0; v < NUM_VEC; v++)
		begin
			gap = $urandom % 8;
			repeat (gap) @(posedge clk);
			#1;
			load_vector(v);
			exp_vec = v;
			armed   = 1'b1;
			start   = 1'b1;
			@(posedge clk);
			#1 start = 1'b0;
			wait_runs(1);
		end

		// start held high gives two separate runs
		@(posedge clk);
		#1;
		load_vector(0);
		exp_vec = 0;
		start   = 1'b1;
		wait_runs(2);
		#1 start = 1'b0;
		repeat (20) @(posedge clk);

		if (done_total != NUM_VEC + 2)
			report_failure("wrong number of done pulses");

		$display("errors: %0d value mismatches, %0d other failures", err_cnt, fail_cnt);
		if (err_cnt == 0 && fail_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/levinson_durbin.sv ====
// levinson-durbin solver top level joining decode, execute and result stages
`timescale 1ns/1ps
`default_nettype none

module levinson_durbin
	import ld_pkg::*;
(
	input  wire      clk,
	input  wire      rst,
	input  logic     start,
	input  ld_rvec_t r,
	output ld_out_t  lpc,
	output ld_idx_t  lpc_addr,
	output logic     lpc_valid,
	output logic     done
);

	ld_op_t  op;
	ld_idx_t idx_i;
	ld_idx_t idx_j;
	logic    div_start;
	logic    div_done;
	logic    solve_done;
	ld_idx_t rd_idx;
	ld_out_t rd_data;

	ld_control u_control (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.div_done   (div_done),
		.op         (op),
		.idx_i      (idx_i),
		.idx_j      (idx_j),
		.div_start  (div_start),
		.solve_done (solve_done)
	);

	ld_datapath u_datapath (
		.clk       (clk),
		.rst       (rst),
		.op        (op),
		.idx_i     (idx_i),
		.idx_j     (idx_j),
		.r         (r),
		.div_start (div_start),
		.div_done  (div_done),
		.rd_idx    (rd_idx),
		.rd_data   (rd_data)
	);

	ld_coef_out u_coef_out (
		.clk        (clk),
		.rst        (rst),
		.solve_done (solve_done),
		.rd_idx     (rd_idx),
		.rd_data    (rd_data),
		.lpc        (lpc),
		.lpc_addr   (lpc_addr),
		.lpc_valid  (lpc_valid),
		.done       (done)
	);

endmodule

`default_nettype wire

// ==== source/ld_coef_out.sv ====
// result stage streaming the final coefficients with address, then done
`timescale 1ns/1ps
`default_nettype none

module ld_coef_out
	import ld_pkg::*;
(
	input  wire     clk,
	input  wire     rst,
	input  logic    solve_done,
	output ld_idx_t rd_idx,
	input  ld_out_t rd_data,
	output ld_out_t lpc,
	output ld_idx_t lpc_addr,
	output logic    lpc_valid,
	output logic    done
);

	ld_idx_t cnt;
	logic    run;

	// counter rests at zero, so a0 is already addressed on solve_done
	assign run    = solve_done || (cnt != '0);
	assign rd_idx = cnt;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			cnt       <= '0;
			lpc_addr  <= '0;
			lpc_valid <= 1'b0;
			done      <= 1'b0;
		end
		else
		begin
			done      <= lpc_valid && (lpc_addr == ld_idx_t'(LD_ORDER));
			lpc_valid <= run;
			if (run)
			begin
				lpc_addr <= cnt;
				cnt      <= (cnt == ld_idx_t'(LD_ORDER)) ? '0 : cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (run)
			lpc <= rd_data;
	end

endmodule

`default_nettype wire

// ==== source/ld_datapath.sv ====
// levinson-durbin execute stage with coefficient banks, sum, reflection and error
`timescale 1ns/1ps
`default_nettype none

module ld_datapath
	import ld_pkg::*;
(
	input  wire      clk,
	input  wire      rst,
	input  ld_op_t   op,
	input  ld_idx_t  idx_i,
	input  ld_idx_t  idx_j,
	input  ld_rvec_t r,
	input  logic     div_start,
	output logic     div_done,
	input  ld_idx_t  rd_idx,
	output ld_out_t  rd_data
);

	// bank a holds the previous order, bank b the one being built
	ld_num_t bank_a [0:LD_ORDER];
	ld_num_t bank_b [0:LD_ORDER];

	ld_num_t sum;
	ld_num_t refl;
	ld_num_t err;
	ld_num_t recip;

	ld_idx_t diff_idx;
	ld_num_t mac_next;
	ld_num_t k_raw;
	ld_num_t k_next;
	ld_num_t upd_next;
	ld_num_t k_sq;
	ld_num_t err_next;

	ld_recip_div u_recip_div (
		.clk       (clk),
		.rst       (rst),
		.div_start (div_start),
		.err       (err),
		.recip     (recip),
		.div_done  (div_done)
	);

	assign diff_idx = idx_i - idx_j;

	// ----------------------------------------
	// arithmetic for the current operation
	// ----------------------------------------
	always_comb
	begin
		mac_next = ld_qadd(sum, ld_qmul(bank_a[idx_j], r[diff_idx]));

		// k = -(Ri + sum) / E
		k_raw = ld_qmul(recip, ld_qadd(r[idx_i], sum));
		if (k_raw[LD_WIDTH-2:0] > LD_ONE[LD_WIDTH-2:0])
			k_next = '0;
		else
			k_next = {~k_raw[LD_WIDTH-1], k_raw[LD_WIDTH-2:0]};

		upd_next = ld_qadd(bank_a[idx_j], ld_qmul(refl, bank_a[diff_idx]));

		// E * (1 - k^2)
		k_sq     = ld_qmul(refl, refl);
		err_next = ld_qmul(err, ld_qadd(LD_ONE, {~k_sq[LD_WIDTH-1], k_sq[LD_WIDTH-2:0]}));
	end

	// ----------------------------------------
	// register update
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		case (op)
			OP_INIT:
			begin
				err <= r[0];
				for (int n = 0; n <= LD_ORDER; n++)
					bank_a[n] <= '0;
			end
			OP_CLR_SUM:
				sum <= '0;
			OP_MAC:
				sum <= mac_next;
			OP_REFL:
			begin
				refl           <= k_next;
				bank_b[idx_i] <= k_next;
			end
			OP_UPD:
				bank_b[idx_j] <= upd_next;
			OP_ERR:
			begin
				err <= err_next;
				for (int n = 0; n <= LD_ORDER; n++)
					bank_a[n] <= bank_b[n];
			end
			default:
			begin
				sum <= sum;
			end
		endcase
	end

	// a0 is always one
	assign rd_data = (rd_idx == '0) ? LD_ONE[LD_OUT_WIDTH-1:0]
	                                : bank_a[rd_idx][LD_OUT_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== source/ld_recip_div.sv ====
// sequential restoring divider forming the reciprocal of the prediction error
`timescale 1ns/1ps
`default_nettype none

module ld_recip_div
	import ld_pkg::*;
(
	input  wire     clk,
	input  wire     rst,
	input  logic    div_start,
	input  ld_num_t err,
	output ld_num_t recip,
	output logic    div_done
);

	logic                        busy;
	logic [$clog2(LD_WIDTH+1)-1:0] cnt;

	ld_num_t             dvd;
	logic [LD_WIDTH-2:0] dvs;
	ld_num_t             rem;
	ld_num_t             quo;
	ld_num_t             rem_shift;
	logic                fits;

	// bring down the next dividend bit and trial subtract
	assign rem_shift = {rem[LD_WIDTH-2:0], dvd[LD_WIDTH-1]};
	assign fits      = (rem_shift >= {1'b0, dvs});

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			busy     <= 1'b0;
			cnt      <= '0;
			div_done <= 1'b0;
		end
		else
		begin
			div_done <= 1'b0;
			if (div_start)
			begin
				busy <= 1'b1;
				cnt  <= '0;
			end
			else if (busy)
			begin
				cnt <= cnt + 1'b1;
				if (cnt == LD_WIDTH - 1)
				begin
					busy     <= 1'b0;
					div_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (div_start)
		begin
			dvd <= LD_RECIP_NUM;
			dvs <= err[LD_WIDTH-2:0];
			rem <= '0;
			quo <= '0;
		end
		else if (busy)
		begin
			dvd <= dvd << 1;
			rem <= fits ? rem_shift - {1'b0, dvs} : rem_shift;
			quo <= {quo[LD_WIDTH-2:0], fits};
		end
	end

	// zero error fits every step and runs to all ones, result is always positive
	assign recip = {1'b0, quo[LD_WIDTH-2:0]};

endmodule

`default_nettype wire

// ==== source/ld_control.sv ====
// levinson-durbin recursion sequencer issuing one datapath operation per cycle
`timescale 1ns/1ps
`default_nettype none

module ld_control
	import ld_pkg::*;
(
	input  wire     clk,
	input  wire     rst,
	input  logic    start,
	input  logic    div_done,
	output ld_op_t  op,
	output ld_idx_t idx_i,
	output ld_idx_t idx_j,
	output logic    div_start,
	output logic    solve_done
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_INIT,
		S_CLR,
		S_MAC,
		S_DIV,
		S_WAIT,
		S_REFL,
		S_UPD,
		S_ERR,
		S_FIN,
		S_DRAIN
	} state_t;

	state_t  state;
	ld_idx_t i;
	ld_idx_t j;
	logic    inner_last;
	logic    order_first;

	// j runs 1 .. i-1 in both inner loops
	assign inner_last  = (j == i - 1'b1);
	assign order_first = (i == ld_idx_t'(1));

	assign idx_i = i;
	assign idx_j = j;

	// ----------------------------------------
	// state and loop counters
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= S_IDLE;
			i     <= '0;
			j     <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (start)
						state <= S_INIT;
				end
				S_INIT:
				begin
					i     <= ld_idx_t'(1);
					state <= S_CLR;
				end
				S_CLR:
				begin
					j     <= ld_idx_t'(1);
					state <= order_first ? S_DIV : S_MAC;
				end
				S_MAC:
				begin
					j     <= j + 1'b1;
					state <= inner_last ? S_DIV : S_MAC;
				end
				S_DIV:
					state <= S_WAIT;
				S_WAIT:
				begin
					if (div_done)
						state <= S_REFL;
				end
				S_REFL:
				begin
					j     <= ld_idx_t'(1);
					state <= order_first ? S_ERR : S_UPD;
				end
				S_UPD:
				begin
					j     <= j + 1'b1;
					state <= inner_last ? S_ERR : S_UPD;
				end
				S_ERR:
				begin
					if (i == ld_idx_t'(LD_ORDER))
					begin
						state <= S_FIN;
					end
					else
					begin
						i     <= i + 1'b1;
						state <= S_CLR;
					end
				end
				S_FIN:
				begin
					j     <= ld_idx_t'(1);
					state <= S_DRAIN;
				end
				// hold off a new run until the result stream and done are out
				S_DRAIN:
				begin
					j <= j + 1'b1;
					if (j == ld_idx_t'(LD_ORDER + 2))
						state <= S_IDLE;
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// operation decode
	// ----------------------------------------
	always_comb
	begin
		op         = OP_IDLE;
		div_start  = 1'b0;
		solve_done = 1'b0;
		case (state)
			S_INIT: op = OP_INIT;
			S_CLR:  op = OP_CLR_SUM;
			S_MAC:  op = OP_MAC;
			S_DIV:  div_start = 1'b1;
			S_REFL: op = OP_REFL;
			S_UPD:  op = OP_UPD;
			S_ERR:  op = OP_ERR;
			S_FIN:  solve_done = 1'b1;
			default: op = OP_IDLE;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/ld_pkg.sv ====
// levinson-durbin shared format constants, types and fixed-point arithmetic
`default_nettype none

package ld_pkg;

	// ----------------------------------------
	// number format
	// ----------------------------------------
	localparam int LD_WIDTH     = 48;
	localparam int LD_FRAC      = 16;
	localparam int LD_OUT_WIDTH = 32;
	localparam int LD_ORDER     = 10;
	localparam int LD_IDX_WIDTH = 4;

	typedef logic [LD_WIDTH-1:0]     ld_num_t;
	typedef logic [LD_OUT_WIDTH-1:0] ld_out_t;
	typedef logic [LD_IDX_WIDTH-1:0] ld_idx_t;

	// autocorrelation set, r[0] is R0
	typedef ld_num_t [LD_ORDER:0] ld_rvec_t;

	localparam ld_num_t LD_ONE = ld_num_t'(1) << LD_FRAC;

	// numerator of the reciprocal, 2^32
	localparam ld_num_t LD_RECIP_NUM = ld_num_t'(1) << (2 * LD_FRAC);

	typedef enum logic [2:0] {
		OP_IDLE,
		OP_INIT,
		OP_CLR_SUM,
		OP_MAC,
		OP_REFL,
		OP_UPD,
		OP_ERR
	} ld_op_t;

	// ----------------------------------------
	// sign-magnitude multiply and add
	// ----------------------------------------
	function automatic ld_num_t ld_qmul(input ld_num_t a, input ld_num_t b);
		logic [2*(LD_WIDTH-1)-1:0] prod;
		ld_num_t res;
		prod = a[LD_WIDTH-2:0] * b[LD_WIDTH-2:0];
		res[LD_WIDTH-1] = a[LD_WIDTH-1] ^ b[LD_WIDTH-1];
		res[LD_WIDTH-2:0] = prod[LD_FRAC +: LD_WIDTH-1];
		return res;
	endfunction

	function automatic ld_num_t ld_qadd(input ld_num_t a, input ld_num_t b);
		logic [LD_WIDTH-2:0] ma;
		logic [LD_WIDTH-2:0] mb;
		ld_num_t res;
		ma = a[LD_WIDTH-2:0];
		mb = b[LD_WIDTH-2:0];
		if (a[LD_WIDTH-1] == b[LD_WIDTH-1])
		begin
			res[LD_WIDTH-2:0] = ma + mb;
			res[LD_WIDTH-1] = a[LD_WIDTH-1];
		end
		else if (ma >= mb)
		begin
			res[LD_WIDTH-2:0] = ma - mb;
			res[LD_WIDTH-1] = a[LD_WIDTH-1];
		end
		else
		begin
			res[LD_WIDTH-2:0] = mb - ma;
			res[LD_WIDTH-1] = b[LD_WIDTH-1];
		end
		// no negative zero
		if (res[LD_WIDTH-2:0] == '0)
			res[LD_WIDTH-1] = 1'b0;
		return res;
	endfunction

endpackage

`default_nettype wire
